/* source/gpu_ctl_consts.svh */
`ifndef GPU_CTL_CONSTS_SVH
`define GPU_CTL_CONSTS_SVH

// warp geometry
`define NUM_THREADS 4
`define NUM_WARPS 4
`define NW_BITS 2

`define XLEN 32

// barriers
`define NB_BITS 2
`define NUM_BARRIERS 4

// reconvergence stack, per warp
`define STACK_DEPTH 4
`define STACK_W 2

// commit record fields
`define UUID_BITS 8
`define NR_BITS 5

`endif

/* source/gpu_ctl_pkg.sv */
`include "gpu_ctl_consts.svh"

package gpu_ctl_pkg;

    typedef enum logic [2:0] {
        TMC    = 3'd0,
        WSPAWN = 3'd1,
        SPLIT  = 3'd2,
        JOIN   = 3'd3,
        BAR    = 3'd4,
        PRED   = 3'd5
    } gpu_op_t;

    // pred travels as a tmc with the narrowed mask
    typedef struct packed {
        logic                    valid;
        logic [`NUM_THREADS-1:0] tmask;
    } tmc_t;

    typedef struct packed {
        logic                  valid;
        logic [`NUM_WARPS-1:0] wmask;
        logic [`XLEN-1:0]      pc;
    } wspawn_t;

    typedef struct packed {
        logic                    valid;
        logic [`NUM_THREADS-1:0] taken;
        logic [`NUM_THREADS-1:0] tmask;
        logic [`XLEN-1:0]        next_pc;
    } split_t;

    typedef struct packed {
        logic                valid;
        logic [`STACK_W-1:0] stack_ptr;
    } join_t;

    typedef struct packed {
        logic                valid;
        logic [`NB_BITS-1:0] id;
        logic                is_global;
        logic [`NW_BITS-1:0] size_m1;
    } barrier_t;

    typedef struct packed {
        logic [`NUM_THREADS-1:0] tmask;
        logic [`XLEN-1:0]        pc;
        logic                    is_else;
    } stack_entry_t;

endpackage

/* source/gpu_ctl_ifs.sv */
`timescale 1ns/1ns
`include "gpu_ctl_consts.svh"

interface warp_ctl_if;

    logic [`NW_BITS-1:0]    wid;
    gpu_ctl_pkg::tmc_t      tmc;
    gpu_ctl_pkg::wspawn_t   wspawn;
    gpu_ctl_pkg::split_t    split;
    gpu_ctl_pkg::join_t     sjoin;
    gpu_ctl_pkg::barrier_t  barrier;
    // stack pointer of wid before any push
    logic [`STACK_W-1:0]    split_ret;

    modport master (output wid, tmc, wspawn, split, sjoin, barrier, input split_ret);
    modport sched  (input wid, tmc, wspawn, barrier);
    modport stack  (input wid, split, sjoin, output split_ret);

endinterface

interface warp_update_if;

    logic                    valid;
    logic [`NW_BITS-1:0]     wid;
    logic [`NUM_THREADS-1:0] tmask;
    logic                    redirect;
    logic [`XLEN-1:0]        pc;
    // warps switched on with a single thread
    logic [`NUM_WARPS-1:0]   wmask;

    modport src (output valid, wid, tmask, redirect, pc, wmask);
    modport dst (input valid, wid, tmask, redirect, pc, wmask);

endinterface

/* source/skid_buffer.sv */
`timescale 1ns/1ns

module skid_buffer #(
    parameter DATAW    = 1,
    parameter PASSTHRU = 0
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             valid_in,
    output logic             ready_in,
    input  logic [DATAW-1:0] data_in,
    output logic [DATAW-1:0] data_out,
    output logic             valid_out,
    input  logic             ready_out
);

    if (PASSTHRU != 0) begin : g_pass
        assign valid_out = valid_in;
        assign data_out  = data_in;
        assign ready_in  = ready_out;
    end else begin : g_reg
        logic             main_valid;
        logic             skid_valid;
        logic [DATAW-1:0] main_data;
        logic [DATAW-1:0] skid_data;
        logic             load_main;
        logic             load_skid;

        // main register free or draining this cycle
        assign load_main = !main_valid || ready_out;
        assign load_skid = valid_in && !skid_valid && !load_main;

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                main_valid <= 1'b0;
                skid_valid <= 1'b0;
            end else if (load_main) begin
                main_valid <= skid_valid || valid_in;
                skid_valid <= 1'b0;
            end else if (load_skid) begin
                skid_valid <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (load_main) begin
                main_data <= skid_valid ? skid_data : data_in;
            end
            if (load_skid) begin
                skid_data <= data_in;
            end
        end

        assign ready_in  = !skid_valid;
        assign valid_out = main_valid;
        assign data_out  = main_data;
    end

endmodule

/* source/wctl_unit.sv */
`timescale 1ns/1ns
`include "gpu_ctl_consts.svh"

module wctl_unit #(
    parameter OUTPUT_REG = 1
) (
    input  logic                                    clk,
    input  logic                                    arst_n,
    input  logic                                    valid,
    input  logic [`UUID_BITS-1:0]                   uuid,
    input  logic [`NW_BITS-1:0]                     wid,
    input  logic [`NUM_THREADS-1:0]                 tmask,
    input  logic [`XLEN-1:0]                        pc,
    input  logic [`XLEN-1:0]                        next_pc,
    input  gpu_ctl_pkg::gpu_op_t                    op,
    input  logic [`NR_BITS-1:0]                     rd,
    input  logic                                    wb,
    input  logic [$clog2(`NUM_THREADS)-1:0]         tid,
    input  logic [`NUM_THREADS-1:0][`XLEN-1:0]      rs1_data,
    input  logic [`NUM_THREADS-1:0][`XLEN-1:0]      rs2_data,
    output logic                                    exe_ready,
    warp_ctl_if.master                              warp_ctl,
    output logic                                    commit_valid,
    output logic [`UUID_BITS-1:0]                   commit_uuid,
    output logic [`NW_BITS-1:0]                     commit_wid,
    output logic [`NUM_THREADS-1:0]                 commit_tmask,
    output logic [`XLEN-1:0]                        commit_pc,
    output logic [`NR_BITS-1:0]                     commit_rd,
    output logic                                    commit_wb,
    output logic [`XLEN-1:0]                        commit_data,
    input  logic                                    commit_ready
);

    localparam DATAW = `UUID_BITS + `NW_BITS + `NUM_THREADS + `XLEN + `NR_BITS + 1 + `STACK_W;

    logic                    fire;
    logic [`XLEN-1:0]        rs1;
    logic [`XLEN-1:0]        rs2;
    logic [`NUM_THREADS-1:0] taken;
    logic [`NUM_THREADS-1:0] then_mask;
    logic [`NUM_WARPS-1:0]   spawn_wmask;
    logic [`STACK_W-1:0]     rsp_ret;

    assign fire = valid && exe_ready;
    assign rs1  = rs1_data[tid];
    assign rs2  = rs2_data[tid];

    for (genvar i = 0; i < `NUM_THREADS; i++) begin : g_taken
        assign taken[i] = rs1_data[i][0];
    end

    // warp 0 is never spawned
    for (genvar i = 0; i < `NUM_WARPS; i++) begin : g_spawn
        assign spawn_wmask[i] = (i != 0) && (rs1 > i);
    end

    assign then_mask = tmask & taken;

    assign warp_ctl.wid = wid;

    assign warp_ctl.tmc.valid = fire && (op == gpu_ctl_pkg::TMC || op == gpu_ctl_pkg::PRED);
    assign warp_ctl.tmc.tmask = (op != gpu_ctl_pkg::PRED) ? rs1[`NUM_THREADS-1:0]
                              : (then_mask != '0) ? then_mask : tmask;

    assign warp_ctl.wspawn = '{valid: fire && (op == gpu_ctl_pkg::WSPAWN),
                               wmask: spawn_wmask, pc: rs2};

    assign warp_ctl.split = '{valid: fire && (op == gpu_ctl_pkg::SPLIT),
                              taken: taken, tmask: tmask, next_pc: next_pc};

    assign warp_ctl.sjoin = '{valid: fire && (op == gpu_ctl_pkg::JOIN),
                              stack_ptr: rs1[`STACK_W-1:0]};

    assign warp_ctl.barrier = '{valid: fire && (op == gpu_ctl_pkg::BAR),
                                id: rs1[`NB_BITS-1:0],
                                is_global: rs1[`XLEN-1],
                                size_m1: `NW_BITS'(rs2 - 1)};

    skid_buffer #(
        .DATAW    (DATAW),
        .PASSTHRU (OUTPUT_REG == 0)
    ) rsp_buf (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid_in  (valid),
        .ready_in  (exe_ready),
        .data_in   ({uuid, wid, tmask, pc, rd, wb, warp_ctl.split_ret}),
        .data_out  ({commit_uuid, commit_wid, commit_tmask, commit_pc,
                     commit_rd, commit_wb, rsp_ret}),
        .valid_out (commit_valid),
        .ready_out (commit_ready)
    );

    assign commit_data = `XLEN'(rsp_ret);

endmodule

/* source/warp_sched_ctl.sv */
`timescale 1ns/1ns
`include "gpu_ctl_consts.svh"

module warp_sched_ctl (
    input  logic                    clk,
    input  logic                    arst_n,
    warp_ctl_if.sched               ctl,
    input  logic [`NUM_THREADS-1:0] cur_tmask,
    warp_update_if.src              upd,
    output logic [`NUM_WARPS-1:0]   stalled_warps
);

    logic [`NW_BITS-1:0]   bar_cnt  [`NUM_BARRIERS];
    logic [`NUM_WARPS-1:0] bar_wait [`NUM_BARRIERS];
    logic                  release_now;

    // spawn keeps the issuing warp's mask and redirects the new warps
    assign upd.valid    = ctl.tmc.valid || ctl.wspawn.valid;
    assign upd.wid      = ctl.wid;
    assign upd.tmask    = ctl.wspawn.valid ? cur_tmask : ctl.tmc.tmask;
    assign upd.redirect = ctl.wspawn.valid;
    assign upd.pc       = ctl.wspawn.pc;
    assign upd.wmask    = ctl.wspawn.valid ? ctl.wspawn.wmask : '0;

    // last arrival on the barrier
    // is_global is handled as local
    assign release_now = (bar_cnt[ctl.barrier.id] == ctl.barrier.size_m1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int b = 0; b < `NUM_BARRIERS; b++) begin
                bar_cnt[b]  <= '0;
                bar_wait[b] <= '0;
            end
        end else if (ctl.barrier.valid) begin
            if (release_now) begin
                bar_cnt[ctl.barrier.id]  <= '0;
                bar_wait[ctl.barrier.id] <= '0;
            end else begin
                bar_cnt[ctl.barrier.id]              <= bar_cnt[ctl.barrier.id] + 1'b1;
                bar_wait[ctl.barrier.id][ctl.wid]    <= 1'b1;
            end
        end
    end

    always_comb begin
        stalled_warps = '0;
        for (int b = 0; b < `NUM_BARRIERS; b++) begin
            stalled_warps = stalled_warps | bar_wait[b];
        end
    end

endmodule

/* source/ipdom_stack.sv */
`timescale 1ns/1ns
`include "gpu_ctl_consts.svh"

module ipdom_stack (
    input  logic        clk,
    input  logic        arst_n,
    warp_ctl_if.stack   ctl,
    warp_update_if.src  upd
);

    gpu_ctl_pkg::stack_entry_t stack_mem [`NUM_WARPS][`STACK_DEPTH];
    logic [`STACK_W-1:0]       sp_q      [`NUM_WARPS];

    logic [`STACK_W-1:0]       sp;
    logic [`NUM_THREADS-1:0]   then_mask;
    logic [`NUM_THREADS-1:0]   else_mask;
    logic                      do_push;
    logic                      do_pop;
    gpu_ctl_pkg::stack_entry_t top;

    assign sp        = sp_q[ctl.wid];
    assign then_mask = ctl.split.tmask & ctl.split.taken;
    assign else_mask = ctl.split.tmask & ~ctl.split.taken;

    // only divergent splits touch the stack
    assign do_push = ctl.split.valid && (then_mask != '0) && (then_mask != ctl.split.tmask);
    assign do_pop  = ctl.sjoin.valid && (ctl.sjoin.stack_ptr != sp);
    assign top     = stack_mem[ctl.wid][sp - 1'b1];

    assign ctl.split_ret = sp;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int w = 0; w < `NUM_WARPS; w++) begin
                sp_q[w] <= '0;
            end
        end else if (do_push) begin
            sp_q[ctl.wid] <= sp + `STACK_W'(2);
        end else if (do_pop) begin
            sp_q[ctl.wid] <= sp - 1'b1;
        end
    end

    // original entry below, else entry on top
    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_mem[ctl.wid][sp]        <= '{tmask: ctl.split.tmask,
                                               pc: ctl.split.next_pc, is_else: 1'b0};
            stack_mem[ctl.wid][sp + 1'b1] <= '{tmask: else_mask,
                                               pc: ctl.split.next_pc, is_else: 1'b1};
        end
    end

    assign upd.valid    = do_push || do_pop;
    assign upd.wid      = ctl.wid;
    assign upd.tmask    = do_push ? then_mask : top.tmask;
    assign upd.redirect = do_pop && top.is_else;
    assign upd.pc       = top.pc;
    assign upd.wmask    = '0;

endmodule

/* source/warp_table.sv */
`timescale 1ns/1ns
`include "gpu_ctl_consts.svh"

module warp_table (
    input  logic                                   clk,
    input  logic                                   arst_n,
    warp_update_if.dst                             sched_upd,
    warp_update_if.dst                             stack_upd,
    input  logic [`NUM_WARPS-1:0]                  stalled_warps,
    input  logic [`NW_BITS-1:0]                    query_wid,
    output logic [`NUM_THREADS-1:0]                cur_tmask,
    output logic [`NUM_WARPS-1:0][`NUM_THREADS-1:0] warp_tmask,
    output logic [`NUM_WARPS-1:0]                  active_warps,
    output logic [`NUM_WARPS-1:0]                  ready_warps,
    output logic                                   redirect_valid,
    output logic [`NW_BITS-1:0]                    redirect_wid,
    output logic [`XLEN-1:0]                       redirect_pc
);

    // commands are one-hot, so the two streams never collide
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            warp_tmask     <= '0;
            warp_tmask[0]  <= `NUM_THREADS'(1);
            redirect_valid <= 1'b0;
        end else begin
            for (int w = 0; w < `NUM_WARPS; w++) begin
                if ((sched_upd.valid && sched_upd.wmask[w]) ||
                    (stack_upd.valid && stack_upd.wmask[w])) begin
                    warp_tmask[w] <= `NUM_THREADS'(1);
                end
            end
            if (sched_upd.valid) begin
                warp_tmask[sched_upd.wid] <= sched_upd.tmask;
            end
            if (stack_upd.valid) begin
                warp_tmask[stack_upd.wid] <= stack_upd.tmask;
            end
            redirect_valid <= (sched_upd.valid && sched_upd.redirect) ||
                              (stack_upd.valid && stack_upd.redirect);
        end
    end

    always_ff @(posedge clk) begin
        if (stack_upd.valid && stack_upd.redirect) begin
            redirect_wid <= stack_upd.wid;
            redirect_pc  <= stack_upd.pc;
        end else if (sched_upd.valid && sched_upd.redirect) begin
            redirect_wid <= sched_upd.wid;
            redirect_pc  <= sched_upd.pc;
        end
    end

    for (genvar w = 0; w < `NUM_WARPS; w++) begin : g_active
        assign active_warps[w] = |warp_tmask[w];
    end

    assign ready_warps = active_warps & ~stalled_warps;
    assign cur_tmask   = warp_tmask[query_wid];

endmodule

/* source/gpu_ctl_top.sv */
`timescale 1ns/1ns
`include "gpu_ctl_consts.svh"

module gpu_ctl_top #(
    parameter OUTPUT_REG = 1
) (
    input  logic                                    clk,
    input  logic                                    arst_n,
    input  logic                                    exe_valid,
    output logic                                    exe_ready,
    input  logic [`UUID_BITS-1:0]                   uuid,
    input  logic [`NW_BITS-1:0]                     wid,
    input  logic [`NUM_THREADS-1:0]                 tmask,
    input  logic [`XLEN-1:0]                        pc,
    input  logic [`XLEN-1:0]                        next_pc,
    input  gpu_ctl_pkg::gpu_op_t                    op,
    input  logic [`NR_BITS-1:0]                     rd,
    input  logic                                    wb,
    input  logic [$clog2(`NUM_THREADS)-1:0]         tid,
    input  logic [`NUM_THREADS*`XLEN-1:0]           rs1_data,
    input  logic [`NUM_THREADS*`XLEN-1:0]           rs2_data,
    output logic                                    commit_valid,
    input  logic                                    commit_ready,
    output logic [`UUID_BITS-1:0]                   commit_uuid,
    output logic [`NW_BITS-1:0]                     commit_wid,
    output logic [`NUM_THREADS-1:0]                 commit_tmask,
    output logic [`XLEN-1:0]                        commit_pc,
    output logic [`NR_BITS-1:0]                     commit_rd,
    output logic                                    commit_wb,
    output logic [`XLEN-1:0]                        commit_data,
    output logic [`NUM_WARPS-1:0][`NUM_THREADS-1:0] warp_tmask,
    output logic [`NUM_WARPS-1:0]                   active_warps,
    output logic [`NUM_WARPS-1:0]                   ready_warps,
    output logic [`NUM_WARPS-1:0]                   stalled_warps,
    output logic                                    redirect_valid,
    output logic [`NW_BITS-1:0]                     redirect_wid,
    output logic [`XLEN-1:0]                        redirect_pc
);

    logic [`NUM_THREADS-1:0] cur_tmask;

    warp_ctl_if    ctl_if ();
    warp_update_if sched_upd_if ();
    warp_update_if stack_upd_if ();

    wctl_unit #(
        .OUTPUT_REG (OUTPUT_REG)
    ) wctl (
        .clk          (clk),
        .arst_n       (arst_n),
        .valid        (exe_valid),
        .uuid         (uuid),
        .wid          (wid),
        .tmask        (tmask),
        .pc           (pc),
        .next_pc      (next_pc),
        .op           (op),
        .rd           (rd),
        .wb           (wb),
        .tid          (tid),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .exe_ready    (exe_ready),
        .warp_ctl     (ctl_if.master),
        .commit_valid (commit_valid),
        .commit_uuid  (commit_uuid),
        .commit_wid   (commit_wid),
        .commit_tmask (commit_tmask),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_wb    (commit_wb),
        .commit_data  (commit_data),
        .commit_ready (commit_ready)
    );

    warp_sched_ctl sched (
        .clk           (clk),
        .arst_n        (arst_n),
        .ctl           (ctl_if.sched),
        .cur_tmask     (cur_tmask),
        .upd           (sched_upd_if.src),
        .stalled_warps (stalled_warps)
    );

    ipdom_stack ipdom (
        .clk    (clk),
        .arst_n (arst_n),
        .ctl    (ctl_if.stack),
        .upd    (stack_upd_if.src)
    );

    // current mask is looked up for the warp on the execute port
    warp_table table_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .sched_upd      (sched_upd_if.dst),
        .stack_upd      (stack_upd_if.dst),
        .stalled_warps  (stalled_warps),
        .query_wid      (wid),
        .cur_tmask      (cur_tmask),
        .warp_tmask     (warp_tmask),
        .active_warps   (active_warps),
        .ready_warps    (ready_warps),
        .redirect_valid (redirect_valid),
        .redirect_wid   (redirect_wid),
        .redirect_pc    (redirect_pc)
    );

endmodule

/* tb/gpu_ctl_assertions.sv */
`timescale 1ns/1ns
`include "gpu_ctl_consts.svh"

module gpu_ctl_assertions (
    input logic                  clk,
    input logic                  arst_n,
    input logic                  valid,
    input logic                  exe_ready,
    input logic [`UUID_BITS-1:0] uuid,
    input logic                  commit_valid,
    input logic                  commit_ready,
    input logic [`UUID_BITS-1:0] commit_uuid
);

    logic fire;

    assign fire = valid && exe_ready;

    // an idle commit port shows the fired record one cycle later
    a_commit_arrival: assert property (@(posedge clk) disable iff (!arst_n)
        fire && !commit_valid |=> commit_valid && (commit_uuid == $past(uuid)))
        else $error("fired record did not reach an idle commit port");

    a_exe_hold: assert property (@(posedge clk) disable iff (!arst_n)
        valid && !exe_ready |=> valid) else $error("execute valid dropped before transfer");

    // commit record held steady under back-pressure
    a_commit_hold: assert property (@(posedge clk) disable iff (!arst_n)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit_uuid))
        else $error("commit record changed while stalled");

endmodule

bind wctl_unit gpu_ctl_assertions chk (
    .clk          (clk),
    .arst_n       (arst_n),
    .valid        (valid),
    .exe_ready    (exe_ready),
    .uuid         (uuid),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready),
    .commit_uuid  (commit_uuid)
);

/* tb/gpu_ctl_tb.sv */
`timescale 1ns/1ns
`include "gpu_ctl_consts.svh"

module gpu_ctl_tb;

    localparam int NUM_ROWS     = 12;
    localparam int RESET_CYCLES = 10;
    localparam int CYCLE_LIMIT  = NUM_ROWS * 20 + RESET_CYCLES;

    typedef struct packed {
        logic [`UUID_BITS-1:0]   uuid;
        logic [`NW_BITS-1:0]     wid;
        logic [`NUM_THREADS-1:0] tmask;
        logic [`XLEN-1:0]        pc;
        logic [`NR_BITS-1:0]     rd;
        logic                    wb;
        logic [`XLEN-1:0]        data;
    } commit_rec_t;

    logic                                    clk;
    logic                                    arst_n;
    logic                                    exe_valid;
    logic                                    exe_ready;
    logic [`UUID_BITS-1:0]                   uuid;
    logic [`NW_BITS-1:0]                     wid;
    logic [`NUM_THREADS-1:0]                 tmask;
    logic [`XLEN-1:0]                        pc;
    logic [`XLEN-1:0]                        next_pc;
    gpu_ctl_pkg::gpu_op_t                    op;
    logic [`NR_BITS-1:0]                     rd;
    logic                                    wb;
    logic [$clog2(`NUM_THREADS)-1:0]         tid;
    logic [`NUM_THREADS*`XLEN-1:0]           rs1_data;
    logic [`NUM_THREADS*`XLEN-1:0]           rs2_data;
    logic                                    commit_valid;
    logic                                    commit_ready;
    logic [`UUID_BITS-1:0]                   commit_uuid;
    logic [`NW_BITS-1:0]                     commit_wid;
    logic [`NUM_THREADS-1:0]                 commit_tmask;
    logic [`XLEN-1:0]                        commit_pc;
    logic [`NR_BITS-1:0]                     commit_rd;
    logic                                    commit_wb;
    logic [`XLEN-1:0]                        commit_data;
    logic [`NUM_WARPS-1:0][`NUM_THREADS-1:0] warp_tmask;
    logic [`NUM_WARPS-1:0]                   active_warps;
    logic [`NUM_WARPS-1:0]                   ready_warps;
    logic [`NUM_WARPS-1:0]                   stalled_warps;
    logic                                    redirect_valid;
    logic [`NW_BITS-1:0]                     redirect_wid;
    logic [`XLEN-1:0]                        redirect_pc;

    // stimulus and expected values per instruction
    gpu_ctl_pkg::gpu_op_t    t_op     [NUM_ROWS];
    logic [`NW_BITS-1:0]     t_wid    [NUM_ROWS];
    logic [`NUM_THREADS-1:0] t_tmask  [NUM_ROWS];
    logic [1:0]              t_tid    [NUM_ROWS];
    logic [`XLEN-1:0]        t_rs1    [NUM_ROWS][`NUM_THREADS];
    logic [`XLEN-1:0]        t_rs2    [NUM_ROWS];
    logic [`XLEN-1:0]        t_data   [NUM_ROWS];
    logic [`NUM_THREADS-1:0] t_mask   [NUM_ROWS];
    logic [`NUM_WARPS-1:0]   t_active [NUM_ROWS];
    logic [`NUM_WARPS-1:0]   t_stall  [NUM_ROWS];
    logic                    t_redir  [NUM_ROWS];
    logic [`XLEN-1:0]        t_rpc    [NUM_ROWS];

    commit_rec_t expect_q[$];
    int          n_rows;
    int          errors;
    int          checks;
    int          cycles;
    logic [15:0] lfsr;

    gpu_ctl_top #(.OUTPUT_REG(1)) UUT (.*);

    always #20 clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic check_mask(input string name, input logic [`NUM_THREADS-1:0] got,
                              input logic [`NUM_THREADS-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [`XLEN-1:0] got,
                              input logic [`XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_active(input string name, input logic [`NUM_WARPS-1:0] got,
                                input logic [`NUM_WARPS-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic add_row(input gpu_ctl_pkg::gpu_op_t o, input int w, input int m, input int t,
                           input int r0, input int r1, input int r2, input int r3,
                           input int r2v, input int data, input int mask, input int act,
                           input int stall, input int redir, input int rpc);
        t_op[n_rows]     = o;
        t_wid[n_rows]    = w[`NW_BITS-1:0];
        t_tmask[n_rows]  = m[`NUM_THREADS-1:0];
        t_tid[n_rows]    = t[1:0];
        t_rs1[n_rows][0] = r0;
        t_rs1[n_rows][1] = r1;
        t_rs1[n_rows][2] = r2;
        t_rs1[n_rows][3] = r3;
        t_rs2[n_rows]    = r2v;
        t_data[n_rows]   = data;
        t_mask[n_rows]   = mask[`NUM_THREADS-1:0];
        t_active[n_rows] = act[`NUM_WARPS-1:0];
        t_stall[n_rows]  = stall[`NUM_WARPS-1:0];
        t_redir[n_rows]  = redir[0];
        t_rpc[n_rows]    = rpc;
        n_rows++;
    endtask

    task automatic build_table();
        // op         wid mask tid rs1 per thread     rs2    data mask act stl rdr rpc
        add_row(gpu_ctl_pkg::TMC,    0, 'h1, 0, 'hf, 0, 0, 0, 0,     0, 'hf, 'h1, 0, 0, 0);
        add_row(gpu_ctl_pkg::WSPAWN, 0, 'hf, 0, 3, 3, 3, 3, 'h100,   0, 'hf, 'h7, 0, 1, 'h100);
        add_row(gpu_ctl_pkg::PRED,   0, 'hf, 0, 1, 0, 1, 0, 0,       0, 'h5, 'h7, 0, 0, 0);
        // no thread taken
        add_row(gpu_ctl_pkg::PRED,   0, 'h5, 0, 0, 0, 0, 0, 0,       0, 'h5, 'h7, 0, 0, 0);
        add_row(gpu_ctl_pkg::TMC,    1, 'h1, 0, 0, 0, 0, 0, 0,       0, 'h0, 'h5, 0, 0, 0);
        // divergent split, then two joins
        add_row(gpu_ctl_pkg::SPLIT,  0, 'h5, 0, 1, 0, 0, 0, 0,       0, 'h1, 'h5, 0, 0, 0);
        add_row(gpu_ctl_pkg::JOIN,   0, 'h1, 0, 0, 0, 0, 0, 0,       2, 'h4, 'h5, 0, 1, 'h214);
        add_row(gpu_ctl_pkg::JOIN,   0, 'h4, 0, 0, 0, 0, 0, 0,       1, 'h5, 'h5, 0, 0, 0);
        // uniform split and its join
        add_row(gpu_ctl_pkg::SPLIT,  0, 'h5, 0, 1, 1, 1, 1, 0,       0, 'h5, 'h5, 0, 0, 0);
        add_row(gpu_ctl_pkg::JOIN,   0, 'h5, 0, 0, 0, 0, 0, 0,       0, 'h5, 'h5, 0, 0, 0);
        // barrier 1 with two members
        add_row(gpu_ctl_pkg::BAR,    0, 'h5, 0, 1, 1, 1, 1, 2,       0, 'h5, 'h5, 1, 0, 0);
        add_row(gpu_ctl_pkg::BAR,    2, 'h1, 0, 1, 1, 1, 1, 2,       0, 'h1, 'h5, 0, 0, 0);
    endtask

    task automatic run_row(input int r);
        commit_rec_t rec;
        int          err_before;
        err_before = errors;
        @(negedge clk);
        op        = t_op[r];
        wid       = t_wid[r];
        tmask     = t_tmask[r];
        tid       = t_tid[r];
        uuid      = `UUID_BITS'(r + 1);
        pc        = `XLEN'(32'h1000 + r * 4);
        next_pc   = `XLEN'(32'h200 + r * 4);
        rd        = `NR_BITS'(r);
        wb        = r[0];
        rs1_data  = {t_rs1[r][3], t_rs1[r][2], t_rs1[r][1], t_rs1[r][0]};
        rs2_data  = {4{t_rs2[r]}};
        exe_valid = 1'b1;
        do begin
            @(posedge clk);
        end while (!exe_ready);
        rec = '{uuid: uuid, wid: wid, tmask: tmask, pc: pc, rd: rd, wb: wb, data: t_data[r]};
        expect_q.push_back(rec);
        @(negedge clk);
        exe_valid = 1'b0;
        check_mask("warp_tmask", warp_tmask[t_wid[r]], t_mask[r]);
        check_active("active_warps", active_warps, t_active[r]);
        check_active("stalled_warps", stalled_warps, t_stall[r]);
        check_active("ready_warps", ready_warps, t_active[r] & ~t_stall[r]);
        check_word("redirect_valid", `XLEN'(redirect_valid), `XLEN'(t_redir[r]));
        if (t_redir[r]) begin
            check_word("redirect_wid", `XLEN'(redirect_wid), `XLEN'(t_wid[r]));
            check_word("redirect_pc", redirect_pc, t_rpc[r]);
        end
        $display("row %0d %s %s", r, t_op[r].name(), (errors == err_before) ? "ok" : "failed");
    endtask

    // random back-pressure on the commit side
    always @(negedge clk) begin
        lfsr         <= lfsr_step(lfsr);
        commit_ready <= lfsr[0];
    end

    always @(posedge clk) begin
        commit_rec_t rec;
        if (arst_n && commit_valid && commit_ready) begin
            if (expect_q.size() == 0) begin
                errors++;
                $display("commit record with uuid 0x%0h arrived with none outstanding",
                         commit_uuid);
            end else begin
                rec = expect_q.pop_front();
                check_word("commit_uuid", `XLEN'(commit_uuid), `XLEN'(rec.uuid));
                check_word("commit_wid", `XLEN'(commit_wid), `XLEN'(rec.wid));
                check_mask("commit_tmask", commit_tmask, rec.tmask);
                check_word("commit_pc", commit_pc, rec.pc);
                check_word("commit_rd", `XLEN'(commit_rd), `XLEN'(rec.rd));
                check_word("commit_wb", `XLEN'(commit_wb), `XLEN'(rec.wb));
                check_word("commit_data", commit_data, rec.data);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        exe_valid    = 1'b0;
        uuid         = '0;
        wid          = '0;
        tmask        = '0;
        pc           = '0;
        next_pc      = '0;
        op           = gpu_ctl_pkg::TMC;
        rd           = '0;
        wb           = 1'b0;
        tid          = '0;
        rs1_data     = '0;
        rs2_data     = '0;
        commit_ready = 1'b0;
        lfsr         = 16'd11200;
        n_rows       = 0;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end
        // drain until no record is left in the buffer either
        while (expect_q.size() != 0 || commit_valid) begin
            @(posedge clk);
        end
        @(negedge clk);
        $display("%0d rows, %0d checks, %0d errors", n_rows, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+source
source/gpu_ctl_pkg.sv
source/gpu_ctl_ifs.sv
source/skid_buffer.sv
source/wctl_unit.sv
source/warp_sched_ctl.sv
source/ipdom_stack.sv
source/warp_table.sv
source/gpu_ctl_top.sv
tb/gpu_ctl_assertions.sv
tb/gpu_ctl_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module gpu_ctl_tb \
    -f files.f -o gpu_ctl_sim

./obj_dir/gpu_ctl_sim > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
else
    exit 1
fi
